// File: verilog.f
+incdir+bench
src/cart_pkg.sv
src/cart_header.sv
src/mbc_regs.sv
src/rom_map.sv
src/cram_ctrl.sv
src/cart_data_select.sv
src/cart_mapper_top.sv
bench/tb_cart_mapper.sv

// File: bench/tb_cart_ref.svh
// reference model for the cartridge mapper testbench
// header decode, bank register rules, rom mapping and rom content

`ifndef TB_CART_REF_SVH
`define TB_CART_REF_SVH

// controller kind as a plain number, 0 for none, else the mbc number
function automatic int kind_of_code(input logic [7:0] code);
	if (code >= 8'd1 && code <= 8'd3)
		return 1;
	if (code >= 8'd5 && code <= 8'd6)
		return 2;
	if (code >= 8'd15 && code <= 8'd19)
		return 3;
	if (code >= 8'd25 && code <= 8'd30)
		return 5;
	return 0;
endfunction

// size codes 0..6 are 2..128 banks, a power of two
function automatic logic [6:0] rom_mask_for_code(input logic [7:0] code);
	if (code <= 8'd6)
		return 7'((2 << code) - 1);
	if (code == 8'd82)
		return 7'd71;
	if (code == 8'd83)
		return 7'd79;
	return 7'd95;
endfunction

function automatic logic [1:0] ram_mask_for_code(input logic [7:0] code);
	return (code == 8'd3) ? 2'd3 : 2'd0;
endfunction

// rom image content, word address folded with a constant
function automatic logic [15:0] rom_word_at(input logic [19:0] waddr);
	return waddr[15:0] ^ 16'hA5C3;
endfunction

// new rom bank register after a write to 2000-3fff
function automatic logic [6:0] bank_after_write(input int kind, input logic [7:0] data);
	if (data[4:0] == 5'd0 && kind != 5)
		return 7'd1;
	return data[6:0];
endfunction

// rom bank seen on the external address for one cpu address
function automatic logic [6:0] mapped_rom_bank(input int kind, input logic [15:0] addr,
		input logic [6:0] rbank, input logic [1:0] xbank, input logic mode,
		input logic [6:0] mask);
	logic [6:0] b;
	if (kind == 0)
		return {6'd0, addr[14]};
	if (addr < 16'h4000 || addr > 16'h7FFF)
		return 7'd0;
	// mbc1 mode 0 stacks the ram bank bits over five rom bits
	if (kind == 1)
		b = mode ? {2'b00, rbank[4:0]} : {xbank, rbank[4:0]};
	else
		b = rbank;
	return b & mask;
endfunction

function automatic logic [1:0] mapped_cram_bank(input int kind, input logic [1:0] xbank,
		input logic mode, input logic [1:0] mask);
	if (kind == 3 || kind == 5 || (kind == 1 && mode))
		return xbank & mask;
	return 2'd0;
endfunction

// mbc2 cells are four bits wide, the top reads as ones
function automatic logic [7:0] cram_byte_read(input int kind, input logic [15:0] addr,
		input logic [7:0] stored);
	if (kind == 2 && addr < 16'hA200)
		return {4'hF, stored[3:0]};
	return stored;
endfunction

`endif

// File: bench/tb_cart_mapper.sv
// testbench for the cartridge mapper
// streams headers, drives cpu reads and writes and checks each
// read byte against a bench model of registers, rom and cart ram

`timescale 1ns/10ps

module tb_cart_mapper;

	// traffic is under 2k cycles, the limit leaves wide margin
	localparam int max_cycles = 20000;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        load_wr;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic        cpu_ce;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic [7:0]  cpu_rdata;
	logic [cart_pkg::rom_word_addr_w-1:0] rom_addr;
	logic [15:0] rom_rdata;

	// bench copy of header and registers
	logic        m_ready;
	logic [7:0]  m_type;
	logic [7:0]  m_rom_code;
	logic [7:0]  m_ram_code;
	logic [6:0]  m_rom_bank;
	logic [1:0]  m_ram_bank;
	logic        m_mode;
	logic        m_ram_en;
	logic [7:0]  shadow [0:32767];
	// cart ram bytes written in the current test, bank over offset
	logic [14:0] written [$];

	// expected byte and rom word address of the read in flight
	logic [7:0]  rd_exp;
	logic [cart_pkg::rom_word_addr_w-1:0] rd_rom_exp;
	logic        chk_valid;
	logic [7:0]  chk_exp;
	logic [cart_pkg::rom_word_addr_w-1:0] chk_rom_exp;
	logic [cart_pkg::rom_word_addr_w-1:0] chk_rom_addr;
	logic [15:0] chk_addr;

	integer      seed;
	logic [31:0] rnd;
	int          cycle_count;
	int          check_count;
	int          err_count;
	int          checks_at_start;
	int          errs_at_start;
	int          i;

	`include "tb_cart_ref.svh"

	cart_mapper_top uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.cpu_ce    (cpu_ce),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.rom_addr  (rom_addr),
		.rom_rdata (rom_rdata)
	);

	always #2 clk_sys = ~clk_sys;

	// rom answers in the same cycle
	assign rom_rdata = rom_word_at(rom_addr);

	// ------------------------------------------------------------------
	// model
	// ------------------------------------------------------------------
	// rom word address the mapper should put out for one cpu address
	function automatic logic [19:0] expect_rom_addr(input logic [15:0] addr);
		logic [6:0] bank;
		bank = mapped_rom_bank(kind_of_code(m_type), addr, m_rom_bank, m_ram_bank, m_mode,
			rom_mask_for_code(m_rom_code));
		return {bank, addr[13:1]};
	endfunction

	function automatic logic [7:0] expect_read(input logic [15:0] addr);
		logic [15:0] word;
		logic [14:0] caddr;
		int          kind;
		kind = kind_of_code(m_type);
		if (!m_ready)
			return 8'h00;
		if (addr[15:13] == 3'b101) begin
			if (!m_ram_en)
				return 8'hFF;
			caddr = {mapped_cram_bank(kind, m_ram_bank, m_mode,
				ram_mask_for_code(m_ram_code)), addr[12:0]};
			return cram_byte_read(kind, addr, shadow[caddr]);
		end
		word = rom_word_at(expect_rom_addr(addr));
		return addr[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		logic [14:0] caddr;
		int          kind;
		kind = kind_of_code(m_type);
		case (addr[15:13])
			3'b000: m_ram_en = (data[3:0] == 4'hA);
			3'b001: m_rom_bank = bank_after_write(kind, data);
			// mbc3 keeps bit 3 for its clock, the bank stays
			3'b010: begin
				if (!(kind == 3 && data[3]))
					m_ram_bank = data[1:0];
			end
			3'b011: begin
				if (kind == 1)
					m_mode = data[0];
			end
			3'b101: begin
				caddr = {mapped_cram_bank(kind, m_ram_bank, m_mode,
					ram_mask_for_code(m_ram_code)), addr[12:0]};
				if (m_ram_en)
					shadow[caddr] = data;
			end
			default: begin
			end
		endcase
	endtask

	// ------------------------------------------------------------------
	// drivers, all on the falling edge
	// ------------------------------------------------------------------
	task automatic load_word(input logic [15:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		load_wr   = 1'b1;
		load_addr = addr;
		load_data = data;
		m_ready   = 1'b1;
		if (addr == 16'h0146)
			m_type = data[15:8];
		if (addr == 16'h0148) begin
			m_rom_code = data[7:0];
			m_ram_code = data[15:8];
		end
		@(negedge clk_sys);
		load_wr = 1'b0;
	endtask

	task automatic load_header(input logic [7:0] kind_code, input logic [7:0] rom_code,
			input logic [7:0] ram_code);
		load_word(16'h0146, {kind_code, 8'h00});
		load_word(16'h0148, {ram_code, rom_code});
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_ce    = 1'b1;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b1;
		cpu_addr  = addr;
		cpu_wdata = data;
		model_write(addr, data);
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		@(negedge clk_sys);
		cpu_ce     = 1'b1;
		cpu_rd     = 1'b1;
		cpu_wr     = 1'b0;
		cpu_addr   = addr;
		rd_exp     = expect_read(addr);
		rd_rom_exp = expect_rom_addr(addr);
	endtask

	task automatic cpu_idle;
		@(negedge clk_sys);
		cpu_ce = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
	endtask

	// selects the bank, then reads back every byte in the list
	task automatic read_written;
		foreach (written[k]) begin
			cpu_write(16'h4000, {6'd0, written[k][14:13]});
			cpu_read({3'b101, written[k][12:0]});
		end
	endtask

	task automatic end_test(input string name);
		cpu_idle();
		// last compare lands on this edge
		@(negedge clk_sys);
		$display("test %-10s %0d reads, %0d errors", name,
			check_count - checks_at_start, err_count - errs_at_start);
		checks_at_start = check_count;
		errs_at_start   = err_count;
	endtask

	// ------------------------------------------------------------------
	// compare, one cycle after each read strobe
	// ------------------------------------------------------------------
	always @(posedge clk_sys) begin
		if (reset) begin
			chk_valid <= 1'b0;
		end else begin
			chk_valid    <= cpu_ce && cpu_rd;
			chk_exp      <= rd_exp;
			chk_rom_exp  <= rd_rom_exp;
			chk_rom_addr <= rom_addr;
			chk_addr     <= cpu_addr;
		end
	end

	always @(negedge clk_sys) begin
		if (chk_valid) begin
			check_count = check_count + 1;
			if (cpu_rdata !== chk_exp) begin
				err_count = err_count + 1;
				$display("Fail at %0t: cpu_rdata expected %02h actual %02h (address %04h)",
					$time, chk_exp, cpu_rdata, chk_addr);
			end
			// rom address taken at the strobe itself
			if (chk_rom_addr !== chk_rom_exp) begin
				err_count = err_count + 1;
				$display("Fail at %0t: rom_addr expected %05h actual %05h (address %04h)",
					$time, chk_rom_exp, chk_rom_addr, chk_addr);
			end
		end
	end

	// watchdog
	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	initial begin
		seed = 32'h5859_5b3e;
		reset = 1'b1;
		load_wr = 1'b0;
		load_addr = 16'h0000;
		load_data = 16'h0000;
		cpu_ce = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = 16'h0000;
		cpu_wdata = 8'h00;
		rd_exp = 8'h00;
		rd_rom_exp = '0;
		cycle_count = 0;
		check_count = 0;
		err_count = 0;
		checks_at_start = 0;
		errs_at_start = 0;
		// model matches the reset state
		m_ready = 1'b0;
		m_type = 8'h00;
		m_rom_code = 8'h00;
		m_ram_code = 8'h00;
		m_rom_bank = 7'd1;
		m_ram_bank = 2'd0;
		m_mode = 1'b0;
		m_ram_en = 1'b0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// no header yet, every read is zero
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			cpu_read(rnd[15:0]);
		end
		end_test("not_ready");

		// plain 32k cart, linear rom
		load_header(8'h00, 8'h00, 8'h00);
		for (i = 0; i < 200; i++) begin
			rnd = $random(seed);
			cpu_read({1'b0, rnd[14:0]});
		end
		end_test("no_mbc");

		// mbc1, 64 banks, every fourth bank write has zero low bits
		load_header(8'h01, 8'h05, 8'h00);
		cpu_write(16'h6000, 8'h00);
		for (i = 0; i < 24; i++) begin
			rnd = $random(seed);
			cpu_write(16'h2000, (i % 4 == 0) ? (rnd[7:0] & 8'hE0) : rnd[7:0]);
			cpu_write(16'h4000, {6'd0, rnd[9:8]});
			// last rounds in mode 1
			cpu_write(16'h6000, {7'd0, i >= 20});
			repeat (8) begin
				rnd = $random(seed);
				cpu_read({2'b01, rnd[13:0]});
			end
			cpu_read({2'b00, rnd[29:16]});
		end
		end_test("mbc1");

		// mbc5 with four ram banks
		load_header(8'h19, 8'h06, 8'h03);
		cpu_write(16'h2000, 8'h00);
		repeat (8) begin
			rnd = $random(seed);
			cpu_read({2'b01, rnd[13:0]});
		end
		cpu_write(16'h0000, 8'h0A);
		written.delete();
		for (i = 0; i < 48; i++) begin
			rnd = $random(seed);
			cpu_write(16'h4000, {6'd0, rnd[14:13]});
			cpu_write({3'b101, rnd[12:0]}, rnd[23:16]);
			written.push_back(rnd[14:0]);
		end
		read_written();
		// gate closed, open bus
		cpu_write(16'h0000, 8'h00);
		repeat (16) begin
			rnd = $random(seed);
			cpu_read({3'b101, rnd[12:0]});
		end
		// other controllers never run on bank zero
		cpu_write(16'h2000, 8'h01);
		end_test("mbc5");

		// mbc2 nibble ram
		load_header(8'h05, 8'h00, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		written.delete();
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			cpu_write({7'b1010000, rnd[8:0]}, rnd[23:16]);
			written.push_back({6'd0, rnd[8:0]});
		end
		foreach (written[k])
			cpu_read({3'b101, written[k][12:0]});
		end_test("mbc2");

		// mbc3, clock select writes must not move the ram bank
		load_header(8'h13, 8'h05, 8'h03);
		cpu_write(16'h0000, 8'h0A);
		written.delete();
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			cpu_write(16'h4000, {6'd0, rnd[14:13]});
			cpu_write({3'b101, rnd[12:0]}, rnd[23:16]);
			written.push_back(rnd[14:0]);
			cpu_write(16'h4000, {4'b0000, 2'b10, rnd[25:24]});
			cpu_read({3'b101, rnd[12:0]});
		end
		read_written();
		end_test("mbc3");

		$display("reads checked %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: src/cart_mapper_top.sv
// cartridge mapper top level
// header snoop, bank registers, rom address mapper, cartridge ram
// and read data selector around one cpu port and one rom port

`timescale 1ns/10ps

module cart_mapper_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	// rom image load stream
	input  logic                                 load_wr,
	input  logic [cart_pkg::cpu_addr_w-1:0]      load_addr,
	input  logic [15:0]                          load_data,
	// cpu cartridge bus
	input  logic                                 cpu_ce,
	input  logic                                 cpu_rd,
	input  logic                                 cpu_wr,
	input  logic [cart_pkg::cpu_addr_w-1:0]      cpu_addr,
	input  logic [7:0]                           cpu_wdata,
	output logic [7:0]                           cpu_rdata,
	// external rom
	output logic [cart_pkg::rom_word_addr_w-1:0] rom_addr,
	input  logic [15:0]                          rom_rdata
);

	// header results
	cart_pkg::mbc_kind_t             mbc_kind;
	logic [cart_pkg::rom_bank_w-1:0] rom_mask;
	logic [cart_pkg::ram_bank_w-1:0] ram_mask;
	logic                            cart_ready;

	// bank registers
	logic [cart_pkg::rom_bank_w-1:0] rom_bank;
	logic [cart_pkg::ram_bank_w-1:0] ram_bank;
	logic                            mbc1_mode;
	logic                            ram_enable;

	// cartridge ram read side
	logic [7:0] cram_q;
	logic       cram_hit;

	cart_header u_header (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_wr    (load_wr),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.mbc_kind   (mbc_kind),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.cart_ready (cart_ready)
	);

	mbc_regs u_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.mbc_kind   (mbc_kind),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.ram_enable (ram_enable)
	);

	rom_map u_rom_map (
		.cpu_addr  (cpu_addr),
		.mbc_kind  (mbc_kind),
		.rom_bank  (rom_bank),
		.ram_bank  (ram_bank),
		.mbc1_mode (mbc1_mode),
		.rom_mask  (rom_mask),
		.rom_addr  (rom_addr)
	);

	cram_ctrl u_cram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.mbc_kind   (mbc_kind),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.ram_mask   (ram_mask),
		.ram_enable (ram_enable),
		.cram_q     (cram_q),
		.cram_hit   (cram_hit)
	);

	cart_data_select u_select (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cpu_rd     (cpu_rd),
		.cpu_addr0  (cpu_addr[0]),
		.rom_rdata  (rom_rdata),
		.cram_q     (cram_q),
		.cram_hit   (cram_hit),
		.cart_ready (cart_ready),
		.cpu_rdata  (cpu_rdata)
	);

endmodule

// File: src/cart_data_select.sv
// read data selector
// registers the rom byte lane at a read strobe and picks between
// rom byte, cartridge ram byte and the not-ready value

`timescale 1ns/10ps

module cart_data_select (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic        cpu_rd,
	input  logic        cpu_addr0,
	input  logic [15:0] rom_rdata,
	input  logic [7:0]  cram_q,
	input  logic        cram_hit,
	input  logic        cart_ready,
	output logic [7:0]  cpu_rdata
);

	// rom byte of the last read
	logic [7:0] rom_byte;
	// ready flag sampled with the same read
	logic       ready_q;

	always_ff @(posedge clk_sys) begin
		// odd address takes the high lane
		if (reset)
			rom_byte <= 8'h00;
		else if (cpu_ce && cpu_rd)
			rom_byte <= cpu_addr0 ? rom_rdata[15:8] : rom_rdata[7:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			ready_q <= 1'b0;
		else if (cpu_ce && cpu_rd)
			ready_q <= cart_ready;
	end

	// all inputs are registered, so the output is one cycle behind
	// the strobe and holds until the next read
	always_comb begin
		if (!ready_q)
			cpu_rdata = cart_pkg::not_ready_data;
		else if (cram_hit)
			cpu_rdata = cram_q;
		else
			cpu_rdata = rom_byte;
	end

endmodule

// File: src/cram_ctrl.sv
// cartridge ram controller
// four 8 KiB banks at a000-bfff with enable gate, open bus
// when disabled and the 4-bit cell mask of mbc2

`timescale 1ns/10ps

module cram_ctrl (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cpu_ce,
	input  logic                                 cpu_rd,
	input  logic                                 cpu_wr,
	input  logic [cart_pkg::cpu_addr_w-1:0]      cpu_addr,
	input  logic [7:0]                           cpu_wdata,
	input  cart_pkg::mbc_kind_t                  mbc_kind,
	input  logic [cart_pkg::ram_bank_w-1:0]      ram_bank,
	input  logic                                 mbc1_mode,
	input  logic [cart_pkg::ram_bank_w-1:0]      ram_mask,
	input  logic                                 ram_enable,
	output logic [7:0]                           cram_q,
	output logic                                 cram_hit
);

	logic [7:0] mem [0:(1 << cart_pkg::cram_addr_w)-1];

	logic [cart_pkg::ram_bank_w-1:0]  bank;
	logic [cart_pkg::cram_addr_w-1:0] cram_addr;
	logic                             is_cram;
	// mbc2 has 512 nibbles at a000-a1ff
	logic                             mbc2_nib;

	// ------------------------------------------------------------------
	// address
	// ------------------------------------------------------------------
	always_comb begin
		case (mbc_kind)
			cart_pkg::mbc_3, cart_pkg::mbc_5: bank = ram_bank & ram_mask;
			// mbc1 banks the ram only in mode 1
			cart_pkg::mbc_1: bank = mbc1_mode ? (ram_bank & ram_mask) : 2'd0;
			default: bank = 2'd0;
		endcase
	end

	assign cram_addr = {bank, cpu_addr[12:0]};
	assign is_cram   = (cpu_addr[15:13] == cart_pkg::region_cram);
	assign mbc2_nib  = (mbc_kind == cart_pkg::mbc_2) && (cpu_addr[15:9] == 7'b1010000);

	// ------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		// writes are dropped while the gate is closed
		if (cpu_ce && cpu_wr && is_cram && ram_enable)
			mem[cram_addr] <= cpu_wdata;
	end

	// read byte, held until the next ram read
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cram_q <= 8'h00;
		end else if (cpu_ce && cpu_rd && is_cram) begin
			if (!ram_enable)
				cram_q <= cart_pkg::cram_open_data;
			else if (mbc2_nib)
				cram_q <= {4'hF, mem[cram_addr][3:0]};
			else
				cram_q <= mem[cram_addr];
		end
	end

	// tells the read selector which source the last read used
	always_ff @(posedge clk_sys) begin
		if (reset)
			cram_hit <= 1'b0;
		else if (cpu_ce && cpu_rd)
			cram_hit <= is_cram;
	end

	a_rd_wr_excl: assert property (
		@(posedge clk_sys) disable iff (reset)
		cpu_ce |-> !(cpu_rd && cpu_wr)
	) else $error("cram_ctrl: read and write in one strobe");

endmodule

// File: src/rom_map.sv
// rom address mapper
// turns the cpu address and bank registers into a word address
// for the external rom, purely combinational

`timescale 1ns/10ps

module rom_map (
	input  logic [cart_pkg::cpu_addr_w-1:0]      cpu_addr,
	input  cart_pkg::mbc_kind_t                  mbc_kind,
	input  logic [cart_pkg::rom_bank_w-1:0]      rom_bank,
	input  logic [cart_pkg::ram_bank_w-1:0]      ram_bank,
	input  logic                                 mbc1_mode,
	input  logic [cart_pkg::rom_bank_w-1:0]      rom_mask,
	output logic [cart_pkg::rom_word_addr_w-1:0] rom_addr
);

	// bank as the controller sees it, before mirroring
	logic [cart_pkg::rom_bank_w-1:0] bank_sel;
	// bank driven onto the rom address
	logic [cart_pkg::rom_bank_w-1:0] bank;

	always_comb begin
		// mbc1 mode 0 puts the ram bank bits on top of the rom bank,
		// mode 1 leaves them for the ram side
		case (mbc_kind)
			cart_pkg::mbc_1: begin
				if (mbc1_mode)
					bank_sel = {2'b00, rom_bank[4:0]};
				else
					bank_sel = {ram_bank, rom_bank[4:0]};
			end
			// mbc2, mbc3 and mbc5 take the register as is
			default: bank_sel = rom_bank;
		endcase
	end

	always_comb begin
		if (mbc_kind == cart_pkg::mbc_none) begin
			// plain 32k cart, linear
			bank = {6'd0, cpu_addr[14]};
		end else if (cpu_addr[15:14] == 2'b00) begin
			// 0000-3fff is always bank 0
			bank = '0;
		end else if (cpu_addr[15:14] == 2'b01) begin
			// switchable window, masked for mirroring of small roms
			bank = bank_sel & rom_mask;
		end else begin
			bank = '0;
		end
	end

	// 16-bit words, cpu_addr[0] picks the byte lane later
	assign rom_addr = {bank, cpu_addr[13:1]};

endmodule

// File: src/mbc_regs.sv
// bank controller registers
// decodes cpu writes below 0x8000 into rom bank, ram bank, mbc1 mode
// and ram enable for mbc1, mbc2, mbc3 and mbc5

`timescale 1ns/10ps

module mbc_regs (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cpu_ce,
	input  logic                                 cpu_wr,
	input  logic [cart_pkg::cpu_addr_w-1:0]      cpu_addr,
	input  logic [7:0]                           cpu_wdata,
	input  cart_pkg::mbc_kind_t                  mbc_kind,
	output logic [cart_pkg::rom_bank_w-1:0]      rom_bank,
	output logic [cart_pkg::ram_bank_w-1:0]      ram_bank,
	output logic                                 mbc1_mode,
	output logic                                 ram_enable
);

	// write strobe and target region
	logic       wr_strobe;
	logic [2:0] region;
	// bank zero in the low five bits is illegal outside mbc5
	logic       bank_zero;
	logic       is_mbc5;

	assign wr_strobe = cpu_ce && cpu_wr;
	assign region    = cpu_addr[15:13];
	assign bank_zero = (cpu_wdata[4:0] == 5'd0);
	assign is_mbc5   = (mbc_kind == cart_pkg::mbc_5);

	// ------------------------------------------------------------------
	// register file
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= cart_pkg::rom_bank_min;
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			ram_enable <= 1'b0;
		end else if (wr_strobe) begin
			case (region)
				// 0000-1fff, magic nibble opens the cart ram
				cart_pkg::region_ram_en: begin
					ram_enable <= (cpu_wdata[3:0] == cart_pkg::ram_enable_key);
				end
				// 2000-3fff, rom bank select
				cart_pkg::region_rom_bank: begin
					if (bank_zero && !is_mbc5)
						rom_bank <= cart_pkg::rom_bank_min;
					else
						rom_bank <= cpu_wdata[6:0];
				end
				// 4000-5fff, ram bank select
				cart_pkg::region_ram_bank: begin
					// mbc3 uses bit 3 for the clock registers, not kept here
					if (!(mbc_kind == cart_pkg::mbc_3 && cpu_wdata[3]))
						ram_bank <= cpu_wdata[1:0];
				end
				// 6000-7fff, banking mode on mbc1 only
				cart_pkg::region_mode: begin
					if (mbc_kind == cart_pkg::mbc_1)
						mbc1_mode <= cpu_wdata[0];
				end
				default: begin
				end
			endcase
		end
	end

	// outside mbc5 the low five rom bank bits are never zero
	a_bank_nonzero: assert property (
		@(posedge clk_sys) disable iff (reset)
		!is_mbc5 |-> (rom_bank[4:0] != 5'd0)
	) else $error("mbc_regs: rom bank low bits zero outside mbc5");

endmodule

// File: src/cart_header.sv
// cartridge header snoop
// watches the rom image stream into external memory and keeps the
// type and size bytes, decodes controller kind and bank masks

`timescale 1ns/10ps

module cart_header (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 load_wr,
	input  logic [cart_pkg::cpu_addr_w-1:0]      load_addr,
	input  logic [15:0]                          load_data,
	output cart_pkg::mbc_kind_t                  mbc_kind,
	output logic [cart_pkg::rom_bank_w-1:0]      rom_mask,
	output logic [cart_pkg::ram_bank_w-1:0]      ram_mask,
	output logic                                 cart_ready
);

	// raw header bytes as captured
	logic [7:0] type_code;
	logic [7:0] rom_size_code;
	logic [7:0] ram_size_code;

	// word hits on the two header locations
	logic hit_type;
	logic hit_size;

	assign hit_type = load_wr && (load_addr == cart_pkg::hdr_type_addr);
	assign hit_size = load_wr && (load_addr == cart_pkg::hdr_size_addr);

	// ------------------------------------------------------------------
	// capture
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_code     <= 8'd0;
			rom_size_code <= 8'd0;
			ram_size_code <= 8'd0;
			cart_ready    <= 1'b0;
		end else begin
			// type byte is the odd byte of the word
			if (hit_type)
				type_code <= load_data[15:8];
			if (hit_size) begin
				rom_size_code <= load_data[7:0];
				ram_size_code <= load_data[15:8];
			end
			// any word of the image marks the cart as present
			if (load_wr)
				cart_ready <= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------
	// table lookups straight from the held bytes, so fields
	// follow one cycle after the matching word
	assign mbc_kind = cart_pkg::decode_kind(type_code);
	assign rom_mask = cart_pkg::rom_mask_of(rom_size_code);
	assign ram_mask = cart_pkg::ram_mask_of(ram_size_code);

	// loader delivers whole words on even byte addresses,
	// an odd one would shift the header bytes by one
	a_load_even: assert property (
		@(posedge clk_sys) disable iff (reset)
		load_wr |-> !load_addr[0]
	) else $error("cart_header: odd load_addr %h", load_addr);

endmodule

// File: src/cart_pkg.sv
// cartridge mapper package
// shared widths, header locations, controller codes and size tables
// for the memory bank controller

package cart_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int cpu_addr_w      = 16;
	// 7-bit bank over a 13-bit word offset
	localparam int rom_word_addr_w = 20;
	localparam int rom_bank_w      = 7;
	localparam int ram_bank_w      = 2;
	// four banks of 8 KiB
	localparam int cram_addr_w     = 15;

	// controller kind, five values need three bits
	typedef enum logic [2:0] {
		mbc_none = 3'd0,
		mbc_1    = 3'd1,
		mbc_2    = 3'd2,
		mbc_3    = 3'd3,
		mbc_5    = 3'd4
	} mbc_kind_t;

	// header words, type byte sits in the upper half of 0x146
	localparam logic [cpu_addr_w-1:0] hdr_type_addr = 16'h0146;
	// low byte rom size, high byte ram size
	localparam logic [cpu_addr_w-1:0] hdr_size_addr = 16'h0148;

	// cpu write regions, cpu_addr[15:13]
	localparam logic [2:0] region_ram_en   = 3'b000;
	localparam logic [2:0] region_rom_bank = 3'b001;
	localparam logic [2:0] region_ram_bank = 3'b010;
	localparam logic [2:0] region_mode     = 3'b011;
	localparam logic [2:0] region_cram     = 3'b101;

	localparam logic [3:0]            ram_enable_key = 4'hA;
	localparam logic [rom_bank_w-1:0] rom_bank_min   = 7'd1;
	localparam logic [7:0]            cram_open_data = 8'hFF;
	localparam logic [7:0]            not_ready_data = 8'h00;

	// ------------------------------------------------------------------
	// header decode tables
	// ------------------------------------------------------------------
	function automatic mbc_kind_t decode_kind(input logic [7:0] code);
		if (code inside {[8'd1:8'd3]})
			return mbc_1;
		if (code inside {[8'd5:8'd6]})
			return mbc_2;
		if (code inside {[8'd15:8'd19]})
			return mbc_3;
		if (code inside {[8'd25:8'd30]})
			return mbc_5;
		// anything unknown runs as a plain 32k cart
		return mbc_none;
	endfunction

	function automatic logic [rom_bank_w-1:0] rom_mask_of(input logic [7:0] code);
		case (code)
			8'd0:    return 7'd1;
			8'd1:    return 7'd3;
			8'd2:    return 7'd7;
			8'd3:    return 7'd15;
			8'd4:    return 7'd31;
			8'd5:    return 7'd63;
			8'd6:    return 7'd127;
			// odd sizes of 72 and 80 banks
			8'd82:   return 7'd71;
			8'd83:   return 7'd79;
			default: return 7'd95;
		endcase
	endfunction

	// only the 32k size is banked
	function automatic logic [ram_bank_w-1:0] ram_mask_of(input logic [7:0] code);
		return (code == 8'd3) ? 2'd3 : 2'd0;
	endfunction

endpackage
